//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pat_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module pat_tb

# no pipefail here, so the log is always checked
./obj_dir/Vpat_tb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
# an assertion stop ends the run without a verdict line
if ! grep -q "SIMULATION PASSED" sim.log; then
	exit 1
fi
exit 0

//--- source/pat_alu.sv
`timescale 1ns/1ps

module pat_alu import pat_core_pkg::*;
(
	pat_exec_if.alu exec,
	input  logic [data_w-1:0] i_a,    // always reg[rn]
	input  logic [data_w-1:0] i_b,    // reg[rs] or immediate
	output logic [data_w-1:0] o_y
);

	logic is_sub;
	logic [data_w-1:0] b_addsub;
	logic [data_w-1:0] sum;
	logic [shamt_w-1:0] shamt;
	logic [data_w-1:0] shlo;
	logic [data_w-1:0] asr;

	// ==================================================
	// shared adder, sub = a + ~b + 1
	// ==================================================
	assign is_sub = (exec.alu_op == alu_sub);
	assign b_addsub = is_sub ? ~i_b : i_b;
	assign sum = i_a + b_addsub + {{(data_w-1){1'b0}}, is_sub};

	// shifts take only the low bits of b
	assign shamt = i_b[shamt_w-1:0];
	// shifting the complement in zeros gives ones after inverting back
	assign shlo = ~((~i_a) << shamt);
	assign asr = $signed(i_a) >>> shamt;

	always_comb
	begin
		case (exec.alu_op)
			alu_or: o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_add, alu_sub: o_y = sum;
			alu_pass_b: o_y = i_b;          // ldi
			alu_not_a: o_y = ~i_a;
			alu_shlz: o_y = i_a << shamt;
			alu_shlo: o_y = shlo;
			alu_shrz: o_y = i_a >> shamt;
			alu_asr: o_y = asr;
			default: o_y = i_b;
		endcase
	end

endmodule

//--- source/pat_commit.sv
`timescale 1ns/1ps

module pat_commit import pat_core_pkg::*, pat_isa_pkg::*;
(
	input  logic clk,
	input  logic reset,
	pat_exec_if.commit exec,
	input  logic [data_w-1:0] i_reg_y,
	input  logic [data_w-1:0] i_imm_y,
	input  logic [data_w-1:0] i_rn_val,
	input  logic [data_w-1:0] i_in0,
	input  logic [data_w-1:0] i_in1,
	input  logic [data_w-1:0] i_in2,
	output logic o_wr_en,
	output logic [reg_adr_w-1:0] o_wr_adr,
	output logic [data_w-1:0] o_wr_data,
	output logic o_branch_take,
	output logic [data_w-1:0] o_offset,
	output logic [data_w-1:0] o_out_data,
	output logic o_out_valid
);

	logic flag_z;
	logic flag_n;
	logic cond_ok;
	logic fire;               // instruction commits this cycle
	logic [data_w-1:0] in_sel;
	logic [data_w-1:0] out_q;

	always_comb
	begin
		case (exec.cond)
			cond_z: cond_ok = flag_z;
			cond_nz: cond_ok = !flag_z;
			cond_n: cond_ok = flag_n;
			default: cond_ok = 1'b1;   // al
		endcase
	end
	assign fire = exec.valid && cond_ok;

	// one-hot port code, anything else falls back to port 0
	always_comb
	begin
		case (exec.imm[2:0])
			3'b010: in_sel = i_in1;
			3'b100: in_sel = i_in2;
			default: in_sel = i_in0;
		endcase
	end

	// ==================================================
	// commit by kind
	// ==================================================
	assign o_wr_en = fire && (exec.kind == kind_alu || exec.kind == kind_in);
	assign o_wr_adr = exec.rn;
	assign o_wr_data = (exec.kind == kind_in) ? in_sel :
		(exec.src_imm ? i_imm_y : i_reg_y);
	assign o_branch_take = fire && (exec.kind == kind_branch);
	assign o_offset = exec.offset;   // sequencer sign-extends
	assign o_out_valid = fire && (exec.kind == kind_out);
	assign o_out_data = o_out_valid ? i_rn_val : out_q;   // port holds last value

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			out_q <= '0;
		end
		else if (fire)
		begin
			if (exec.kind == kind_test)
			begin
				flag_z <= (i_rn_val == '0);
				flag_n <= i_rn_val[data_w-1];   // sign bit
			end
			if (exec.kind == kind_out)
				out_q <= i_rn_val;
		end
	end

endmodule

//--- source/pat_core.sv
`timescale 1ns/1ps

module pat_core import pat_core_pkg::*, pat_isa_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_fetch_ack,
	input  logic [instr_w-1:0] i_instr,
	input  logic [data_w-1:0] i_in0,
	input  logic [data_w-1:0] i_in1,
	input  logic [data_w-1:0] i_in2,
	output logic o_fetch_req,
	output logic [pc_w-1:0] o_pc,
	output logic [data_w-1:0] o_out_data,
	output logic o_out_valid
);

	logic [instr_w-1:0] instr;
	logic execute;
	logic branch_take;
	logic [data_w-1:0] offset;
	logic [data_w-1:0] rd_a;       // reg[rn]
	logic [data_w-1:0] rd_b;       // reg[rs]
	logic [data_w-1:0] reg_y;
	logic [data_w-1:0] imm_y;
	logic wr_en;
	logic [reg_adr_w-1:0] wr_adr;
	logic [data_w-1:0] wr_data;

	pat_exec_if exec ();

	// ==================================================
	// fetch and decode
	// ==================================================
	pat_sequencer u_seq (
		.clk(clk), .reset(reset),
		.i_fetch_ack(i_fetch_ack), .i_instr(i_instr),
		.i_branch_take(branch_take), .i_offset(offset),
		.o_fetch_req(o_fetch_req), .o_pc(o_pc),
		.o_instr(instr), .o_execute(execute)
	);

	pat_decoder u_dec (.i_instr(instr), .i_execute(execute), .exec(exec));

	pat_regfile u_rf (
		.clk(clk), .reset(reset),
		.i_rd_a_adr(exec.rn), .i_rd_b_adr(exec.rs),
		.i_wr_en(wr_en), .i_wr_adr(wr_adr), .i_wr_data(wr_data),
		.o_rd_a(rd_a), .o_rd_b(rd_b)
	);

	// two alus side by side, no operand mux in front of them
	pat_alu reg_alu (.exec(exec), .i_a(rd_a), .i_b(rd_b), .o_y(reg_y));
	pat_alu imm_alu (.exec(exec), .i_a(rd_a), .i_b(exec.imm), .o_y(imm_y));

	pat_commit u_commit (
		.clk(clk), .reset(reset), .exec(exec),
		.i_reg_y(reg_y), .i_imm_y(imm_y), .i_rn_val(rd_a),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_wr_en(wr_en), .o_wr_adr(wr_adr), .o_wr_data(wr_data),
		.o_branch_take(branch_take), .o_offset(offset),
		.o_out_data(o_out_data), .o_out_valid(o_out_valid)
	);

endmodule

//--- source/pat_core_pkg.sv
package pat_core_pkg;

	localparam int data_w = 8;                      // datapath width
	localparam int pc_w = 10;                       // program counter width
	localparam int reg_count = 8;                   // register file depth
	localparam int reg_adr_w = $clog2(reg_count);
	localparam int shamt_w = $clog2(data_w);        // shift amount bits

	// fetch handshake sequencer
	typedef enum logic [1:0] {
		seq_fetch,      // req high, waiting for ack
		seq_release,    // instr captured, waiting for ack to drop
		seq_execute     // single commit cycle
	} seq_state_e;

	typedef enum logic [3:0] {
		alu_or, alu_and, alu_add, alu_sub, alu_pass_b,
		alu_not_a, alu_shlz, alu_shlo, alu_shrz, alu_asr
	} alu_op_e;

	// what the commit unit does with a decoded instruction
	typedef enum logic [2:0] {
		kind_alu, kind_in, kind_out, kind_test, kind_branch, kind_none
	} kind_e;

endpackage

//--- source/pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder import pat_core_pkg::*, pat_isa_pkg::*;
(
	input  logic [instr_w-1:0] i_instr,
	input  logic i_execute,
	pat_exec_if.decoder exec
);

	logic [rn_w-1:0] f_rn;
	logic [cond_w-1:0] f_cond;
	logic [imm8_w-1:0] f_imm8;
	op8_e op8;
	op3_e op3;
	op0_e op0;
	logic is_i8;
	logic is_i3;
	alu_op_e op_sel;
	kind_e kind_sel;

	// ==================================================
	// field split
	// ==================================================
	assign f_rn = i_instr[rn_lsb +: rn_w];
	assign f_cond = i_instr[cond_lsb +: cond_w];
	assign op8 = op8_e'(i_instr[op8_lsb +: op_w]);
	assign f_imm8 = i_instr[imm8_lsb +: imm8_w];
	assign op3 = op3_e'(f_imm8[op3_lsb +: op_w]);   // only meaningful behind i3 prefix
	assign op0 = op0_e'(f_imm8[op0_lsb +: op_w]);   // only meaningful behind i0 prefix

	assign is_i8 = (op8 != op8_i3_pfx);
	assign is_i3 = !is_i8 && (op3 != op3_i0_pfx);   // anything left over is i0

	// opcode -> alu operation and commit kind
	always_comb
	begin
		op_sel = alu_pass_b;
		kind_sel = kind_alu;   // most opcodes write rn
		if (is_i8)
			case (op8)
				op8_ori, op8_orr: op_sel = alu_or;
				op8_andi, op8_andr: op_sel = alu_and;
				op8_addi, op8_addr: op_sel = alu_add;
				op8_subi, op8_subr: op_sel = alu_sub;
				op8_ldi: op_sel = alu_pass_b;   // rn <= imm8 via imm alu
				op8_bf: kind_sel = kind_branch;
				default: kind_sel = kind_none;  // undefined codes behave as nop
			endcase
		else if (is_i3)
			case (op3)
				op3_shlzi, op3_shlzr: op_sel = alu_shlz;
				op3_shloi, op3_shlor: op_sel = alu_shlo;
				op3_shrzi, op3_shrzr: op_sel = alu_shrz;
				op3_asri, op3_asrr: op_sel = alu_asr;
				op3_in: kind_sel = kind_in;
				op3_out: kind_sel = kind_out;
				default: kind_sel = kind_none;
			endcase
		else
			case (op0)
				op0_not: op_sel = alu_not_a;
				op0_test: kind_sel = kind_test;
				default: kind_sel = kind_none;  // nop and the rest
			endcase
	end

	assign exec.valid = i_execute;
	assign exec.alu_op = op_sel;
	assign exec.kind = kind_sel;
	// even opcode picks the immediate form, i0 always works on registers
	assign exec.src_imm = (is_i8 && !op8[0]) || (is_i3 && !op3[0]);
	assign exec.imm = is_i8 ? f_imm8 : {{(data_w-imm3_w){1'b0}}, f_imm8[imm3_w-1:0]};
	assign exec.rn = f_rn;
	assign exec.rs = f_imm8[imm3_w-1:0];
	assign exec.cond = cond_e'(f_cond);
	assign exec.offset = f_imm8;

endmodule

//--- source/pat_exec_if.sv
`timescale 1ns/1ps

// one decoded instruction, decoder -> both alus and commit
interface pat_exec_if import pat_core_pkg::*, pat_isa_pkg::*; ();

	logic valid;                    // high only in the execute cycle
	alu_op_e alu_op;
	kind_e kind;
	logic src_imm;                  // 1: take imm_alu result
	logic [reg_adr_w-1:0] rn;       // source and destination reg
	logic [reg_adr_w-1:0] rs;       // second source, imm8[2:0]
	logic [data_w-1:0] imm;         // imm8 or zero-extended imm3
	cond_e cond;
	logic [data_w-1:0] offset;      // raw imm8 for bf

	modport decoder (
		output valid, alu_op, kind, src_imm, rn, rs, imm, cond, offset
	);

	// alus only need the operation, operands come on ports
	modport alu (input alu_op);

	modport commit (
		input valid, kind, src_imm, rn, imm, cond, offset
	);

endinterface

//--- source/pat_isa_pkg.sv
package pat_isa_pkg;

	// ==================================================
	// instruction format, msb first: rn | cond | op8 | imm8
	// ==================================================
	localparam int instr_w = 17;   // whole instruction
	localparam int rn_w = 3;       // register index
	localparam int cond_w = 2;     // condition code
	localparam int op_w = 4;       // every opcode field is a nibble
	localparam int imm8_w = 8;     // i8 immediate / branch offset
	localparam int imm3_w = 3;     // i3 immediate, low bits of imm8

	// field positions inside the instruction
	localparam int rn_lsb = 14;
	localparam int cond_lsb = 12;
	localparam int op8_lsb = 8;
	localparam int imm8_lsb = 0;

	// sub-opcode positions inside imm8
	localparam int op3_lsb = 4;
	localparam int op0_lsb = 0;

	// i8 space, even code = immediate form
	typedef enum logic [op_w-1:0] {
		op8_ori = 4'd0,
		op8_orr = 4'd1,
		op8_andi = 4'd2,
		op8_andr = 4'd3,
		op8_addi = 4'd4,
		op8_addr = 4'd5,
		op8_subi = 4'd6,
		op8_subr = 4'd7,
		op8_ldi = 4'd8,
		op8_bf = 4'd13,
		op8_i3_pfx = 4'd15     // escape into the i3 space
	} op8_e;

	// i3 space, carried in imm8[7:4]
	typedef enum logic [op_w-1:0] {
		op3_shlzi = 4'd0,
		op3_shlzr = 4'd1,
		op3_shloi = 4'd2,
		op3_shlor = 4'd3,
		op3_shrzi = 4'd4,
		op3_shrzr = 4'd5,
		op3_asri = 4'd6,
		op3_asrr = 4'd7,
		op3_in = 4'd8,
		op3_out = 4'd11,
		op3_i0_pfx = 4'd15     // escape into the i0 space
	} op3_e;

	// i0 space, carried in imm8[3:0]
	typedef enum logic [op_w-1:0] {
		op0_not = 4'd0,
		op0_test = 4'd2,
		op0_nop = 4'd15
	} op0_e;

	typedef enum logic [cond_w-1:0] {
		cond_z = 2'd0,    // Z set
		cond_nz = 2'd1,   // Z clear
		cond_n = 2'd2,    // N set
		cond_al = 2'd3    // always
	} cond_e;

endpackage

//--- source/pat_regfile.sv
`timescale 1ns/1ps

module pat_regfile import pat_core_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [reg_adr_w-1:0] i_rd_a_adr,   // rn
	input  logic [reg_adr_w-1:0] i_rd_b_adr,   // rs
	input  logic i_wr_en,
	input  logic [reg_adr_w-1:0] i_wr_adr,
	input  logic [data_w-1:0] i_wr_data,
	output logic [data_w-1:0] o_rd_a,
	output logic [data_w-1:0] o_rd_b
);

	logic [data_w-1:0] regs [reg_count];

	// async reads, so both alus see operands inside the execute cycle
	assign o_rd_a = regs[i_rd_a_adr];
	assign o_rd_b = regs[i_rd_b_adr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (i_wr_en)
			regs[i_wr_adr] <= i_wr_data;   // lands at end of execute
	end

endmodule

//--- source/pat_sequencer.sv
`timescale 1ns/1ps

module pat_sequencer import pat_core_pkg::*, pat_isa_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_fetch_ack,
	input  logic [instr_w-1:0] i_instr,
	input  logic i_branch_take,          // already qualified by commit
	input  logic [data_w-1:0] i_offset,
	output logic o_fetch_req,
	output logic [pc_w-1:0] o_pc,
	output logic [instr_w-1:0] o_instr,
	output logic o_execute
);

	seq_state_e state;
	logic req_q;
	logic capture;
	logic [pc_w-1:0] pc_q;
	logic [pc_w-1:0] pc_jump;
	logic [pc_w-1:0] pc_next;
	logic [instr_w-1:0] instr_q;

	// ack seen while requesting
	assign capture = (state == seq_fetch) && req_q && i_fetch_ack;

	// bf is relative to its own address
	assign pc_jump = pc_q + {{(pc_w-data_w){i_offset[data_w-1]}}, i_offset};
	assign pc_next = i_branch_take ? pc_jump : pc_q + pc_w'(1);

	// ==================================================
	// four-phase fetch handshake
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= seq_fetch;
			req_q <= 1'b0;
			pc_q <= '0;
		end
		else
		begin
			case (state)
				seq_fetch:
				begin
					if (!req_q)
						req_q <= 1'b1;   // first request after reset
					else if (capture)
					begin
						req_q <= 1'b0;
						state <= seq_release;
					end
				end
				seq_release:
					if (!i_fetch_ack)
						state <= seq_execute;   // responder finished
				seq_execute:
				begin
					pc_q <= pc_next;
					req_q <= 1'b1;   // next fetch right after the commit cycle
					state <= seq_fetch;
				end
				default: state <= seq_fetch;
			endcase
		end
	end

	// instruction register, plain payload
	always_ff @(posedge clk)
	begin
		if (capture)
			instr_q <= i_instr;
	end

	assign o_fetch_req = req_q;
	assign o_pc = pc_q;
	assign o_instr = instr_q;
	assign o_execute = (state == seq_execute);

endmodule

//--- tb/pat_chk.sv
`timescale 1ns/1ps

module pat_chk
(
	input  logic clk,
	input  logic reset,
	input  logic i_fetch_req,
	input  logic i_fetch_ack,
	input  logic i_out_valid
);

	// ==================================================
	// fetch handshake
	// ==================================================
	req_holds_until_ack: assert property (@(posedge clk) disable iff (reset)
		i_fetch_req && !i_fetch_ack |=> i_fetch_req)
		else $error("fetch req dropped before the responder acked");

	// a new request only after the previous ack has gone low
	req_rise_ack_low: assert property (@(posedge clk) disable iff (reset)
		$rose(i_fetch_req) |-> !i_fetch_ack)
		else $error("fetch req rose while ack was still high");

	// out strobe belongs to a single execute cycle
	out_single_cycle: assert property (@(posedge clk) disable iff (reset)
		i_out_valid |=> !i_out_valid)
		else $error("out valid lasted longer than one cycle");

	quiet_in_reset: assert property (@(posedge clk)
		reset |=> !i_fetch_req && !i_out_valid)
		else $error("fetch req or out valid active during reset");

endmodule

bind pat_core pat_chk u_chk (
	.clk(clk),
	.reset(reset),
	.i_fetch_req(o_fetch_req),
	.i_fetch_ack(i_fetch_ack),
	.i_out_valid(o_out_valid)
);

//--- tb/pat_tb_model.svh
// ==================================================
// instruction set model, one call per fetched instruction
// ==================================================
logic [data_w-1:0] m_regs [8];
logic m_z;
logic m_n;
logic [pc_w-1:0] m_pc;              // address of the next fetch
logic [data_w-1:0] exp_out_q [$];   // values the out strobes must carry
int model_outs;

task automatic model_reset();
	begin
		for (int i = 0; i < 8; i++)
			m_regs[i] = '0;
		m_z = 1'b0;
		m_n = 1'b0;
		m_pc = '0;
		model_outs = 0;
		exp_out_q.delete();
	end
endtask

task automatic model_step(input logic [instr_w-1:0] ins, input logic [data_w-1:0] p0,
	input logic [data_w-1:0] p1, input logic [data_w-1:0] p2);
	logic [2:0] rn;
	logic [1:0] cond;
	logic [3:0] op8;
	logic [7:0] imm8;
	logic ok;
	logic wr;
	logic [data_w-1:0] a;
	logic [data_w-1:0] b;
	logic [data_w-1:0] y;
	logic [2:0] s;
	logic [pc_w-1:0] next_pc;
	begin
		{rn, cond, op8, imm8} = ins;
		a = m_regs[rn];
		wr = 1'b0;
		y = '0;
		next_pc = m_pc + pc_w'(1);   // untaken bf too
		case (cond)
			cond_z: ok = m_z;
			cond_nz: ok = !m_z;
			cond_n: ok = m_n;
			default: ok = 1'b1;
		endcase
		if (ok)
		begin
			if (op8 != op8_i3_pfx)
			begin
				b = op8[0] ? m_regs[imm8[2:0]] : imm8;   // odd = register form
				wr = 1'b1;
				case (op8)
					op8_ori, op8_orr: y = a | b;
					op8_andi, op8_andr: y = a & b;
					op8_addi, op8_addr: y = a + b;
					op8_subi, op8_subr: y = a - b;
					op8_ldi: y = imm8;
					op8_bf:
					begin
						wr = 1'b0;
						next_pc = m_pc + pc_w'(signed'(imm8));
					end
					default: wr = 1'b0;   // undefined, nop
				endcase
			end
			else if (imm8[7:4] != op3_i0_pfx)
			begin
				b = imm8[4] ? m_regs[imm8[2:0]] : data_w'(imm8[2:0]);
				s = b[2:0];
				wr = 1'b1;
				case (imm8[7:4])
					op3_shlzi, op3_shlzr: y = a << s;
					op3_shloi, op3_shlor: y = (a << s) | ~(8'hff << s);   // ones shifted in
					op3_shrzi, op3_shrzr: y = a >> s;
					op3_asri, op3_asrr: y = (a >> s) | (a[7] ? ~(8'hff >> s) : 8'h00);
					op3_in:
					begin
						case (imm8[2:0])
							3'b010: y = p1;
							3'b100: y = p2;
							default: y = p0;   // 001 and any other code
						endcase
					end
					op3_out:
					begin
						wr = 1'b0;
						exp_out_q.push_back(a);
						model_outs++;
					end
					default: wr = 1'b0;
				endcase
			end
			else
			begin
				case (imm8[3:0])
					op0_not:
					begin
						y = ~a;
						wr = 1'b1;
					end
					op0_test:
					begin
						m_z = (a == 8'h00);
						m_n = a[7];
					end
					default: ;   // nop
				endcase
			end
		end
		if (wr)
			m_regs[rn] = y;
		m_pc = next_pc;
	end
endtask

//--- tb/pat_tb.sv
`timescale 1ns/1ps

module pat_tb import pat_isa_pkg::*, pat_core_pkg::*;
();

	localparam int prog_len = 200;
	localparam int cycle_limit = prog_len * 10 + 50;   // at most 10 cycles per instruction

	logic clk;
	logic reset;
	logic i_fetch_ack;
	logic [instr_w-1:0] i_instr;
	logic [data_w-1:0] i_in0;
	logic [data_w-1:0] i_in1;
	logic [data_w-1:0] i_in2;
	logic o_fetch_req;
	logic [pc_w-1:0] o_pc;
	logic [data_w-1:0] o_out_data;
	logic o_out_valid;

	integer seed;
	int cycles;
	int seen_outs;
	logic [instr_w-1:0] prog [2**pc_w];   // only the first prog_len words are used

	`include "pat_tb_model.svh"

	pat_core DUT (
		.clk(clk), .reset(reset),
		.i_fetch_ack(i_fetch_ack), .i_instr(i_instr),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_fetch_req(o_fetch_req), .o_pc(o_pc),
		.o_out_data(o_out_data), .o_out_valid(o_out_valid)
	);

	always #50 clk = ~clk;

	// ==================================================
	// checking helpers
	// ==================================================
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		begin
			if (got !== exp)
			begin
				$display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
				$display("SIMULATION FAILED");
				$fatal(1, "stopped at first error");
			end
		end
	endtask

	task automatic abort_run(input string why);
		begin
			$display("ERROR at %0t: %s", $time, why);
			$display("SIMULATION FAILED");
			$fatal(1, "run aborted");
		end
	endtask

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	// one random instruction over all kept opcodes
	function automatic logic [instr_w-1:0] make_instr();
		logic [31:0] pick;
		logic [31:0] r;
		logic [3:0] op8;
		logic [7:0] imm8;
		logic [2:0] code;
		begin
			pick = rand_word() % 32'd20;
			r = rand_word();
			op8 = op8_i3_pfx;
			imm8 = r[15:8];
			case (r[22:21])   // in port code, mostly one-hot
				2'd0: code = 3'b001;
				2'd1: code = 3'b010;
				2'd2: code = 3'b100;
				default: code = r[20:18];
			endcase
			if (pick < 32'd8)
				op8 = pick[3:0];   // or/and/add/sub in both forms
			else if (pick < 32'd10)
				op8 = op8_ldi;
			else if (pick == 32'd10)
			begin
				op8 = op8_bf;
				imm8 = {6'b0, r[17:16]} + 8'd1;   // forward by 1..4
			end
			else if (pick < 32'd13)
				imm8 = {1'b0, r[18:16], r[11:8]};   // the eight shift codes
			else if (pick == 32'd13)
				imm8 = {op3_in, 1'b0, code};
			else if (pick < 32'd17)
				imm8 = {op3_out, r[11:8]};   // outs are frequent, they carry the checks
			else if (pick == 32'd17)
				imm8 = {op3_i0_pfx, op0_not};
			else if (pick == 32'd18)
				imm8 = {op3_i0_pfx, op0_test};
			else
				imm8 = {op3_i0_pfx, op0_nop};
			make_instr = {r[2:0], r[4:3], op8, imm8};
		end
	endfunction

	// plays the instruction memory for one fetch
	task automatic serve_fetch();
		int wait_ack;
		int wait_drop;
		logic [31:0] r;
		logic [instr_w-1:0] ins;
		begin
			wait_ack = int'(rand_word() % 32'd4);
			wait_drop = int'(rand_word() % 32'd3);
			r = rand_word();
			ins = prog[m_pc];
			repeat (wait_ack) @(posedge clk);
			@(posedge clk);
			i_fetch_ack <= 1'b1;
			i_instr <= ins;
			i_in0 <= r[7:0];
			i_in1 <= r[15:8];
			i_in2 <= r[23:16];
			model_step(ins, r[7:0], r[15:8], r[23:16]);
			@(negedge clk);
			while (o_fetch_req)   // core has not captured yet
				@(negedge clk);
			repeat (wait_drop) @(posedge clk);
			@(posedge clk);
			i_fetch_ack <= 1'b0;
		end
	endtask

	// ==================================================
	// monitors
	// ==================================================
	always @(negedge clk)
	begin : out_monitor
		logic [data_w-1:0] expected;
		if (!reset && o_out_valid)
		begin
			if (exp_out_q.size() == 0)
				abort_run("out strobe seen with no out committed by the model");
			else
			begin
				expected = exp_out_q.pop_front();
				seen_outs++;
				check_value(32'(o_out_data), 32'(expected), "out data");
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run("timeout, the program did not finish within the cycle limit");
	end

	initial
	begin : stimulus
		logic done;
		clk = 1'b0;
		reset = 1'b1;
		i_fetch_ack = 1'b0;
		i_instr = '0;
		i_in0 = '0;
		i_in1 = '0;
		i_in2 = '0;
		seed = 32'hc54d4ffe;
		cycles = 0;
		seen_outs = 0;
		done = 1'b0;
		for (int i = 0; i < prog_len; i++)
			prog[i] = make_instr();
		model_reset();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		while (!done)
		begin
			@(negedge clk);
			while (!o_fetch_req)   // wait for the rising request
				@(negedge clk);
			check_value(32'(o_pc), 32'(m_pc), "fetch pc");
			if (int'(m_pc) >= prog_len)
				done = 1'b1;   // fetch past the last word ends the program
			else
				serve_fetch();
		end
		check_value(seen_outs, model_outs, "out strobe count");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+tb
source/pat_isa_pkg.sv
source/pat_core_pkg.sv
source/pat_exec_if.sv
source/pat_decoder.sv
source/pat_regfile.sv
source/pat_alu.sv
source/pat_commit.sv
source/pat_sequencer.sv
source/pat_core.sv
tb/pat_chk.sv
tb/pat_tb.sv
